/* hdl/csr_pkg.sv */
// ##########################################################
// CSR package
// Shared MMIO types, local CSR indices and the device
// feature header builder for the control/status block
// ##########################################################

package csr_pkg;

    // MMIO address in 4-byte units, as it arrives from the host
    typedef logic [15:0] mmio_addr_t;

    // Request tag, echoed back unchanged in the response
    typedef logic [8:0] tid_t;

    // One 64-bit CSR word
    typedef logic [63:0] csr_data_t;

    // Index into the 16-entry system-register bank
    typedef logic [3:0] sreg_addr_t;

    // Local CSR index, taken from address bits 3 to 1
    typedef logic [2:0] csr_idx_t;

    // Local CSR map, one entry per 8-byte word
    localparam csr_idx_t CSR_DFH        = 3'd0;
    localparam csr_idx_t CSR_ID_L       = 3'd1;
    localparam csr_idx_t CSR_ID_H       = 3'd2;
    localparam csr_idx_t CSR_RSVD       = 3'd3;
    localparam csr_idx_t CSR_SCRATCH    = 3'd4;
    localparam csr_idx_t CSR_SREG_ADDR  = 3'd5;
    localparam csr_idx_t CSR_SREG_WDATA = 3'd6;
    localparam csr_idx_t CSR_SREG_READ  = 3'd7;

    // Builds the AFU device feature header
    // Feature type 1 sits in the top nibble and bit 40 marks the end of the list
    function automatic csr_data_t dfh_afu();
        csr_data_t hdr;
        hdr = '0;
        hdr[63:60] = 4'd1;
        // Only one feature header exists in this block
        hdr[40] = 1'b1;
        return hdr;
    endfunction

endpackage

/* hdl/csr_wr.sv */
// ##########################################################
// MMIO write decoder
// Holds the scratch and system-register staging registers
// and forwards system-register writes to the bank
// ##########################################################

module csr_wr
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req_valid,
    input  logic       req_write,
    input  mmio_addr_t req_addr,
    input  csr_data_t  req_data,
    output csr_data_t  scratch,
    output sreg_addr_t sreg_addr,
    output csr_data_t  sreg_wdata_reg,
    output logic       sreg_wr_en
);

    // Local write decode, same address window as the read side
    logic     is_wr;
    csr_idx_t idx;

    assign is_wr = req_valid && req_write && (req_addr < 16'd16) && !req_addr[0];
    assign idx   = req_addr[3:1];

    // The bank stores req_data at the edge ending the request cycle
    // It takes its index from sreg_addr, so the index must be staged first
    assign sreg_wr_en = is_wr && (idx == CSR_SREG_WDATA);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            scratch        <= '0;
            sreg_addr      <= '0;
            sreg_wdata_reg <= '0;
        end
        else if (is_wr)
        begin
            case (idx)
                CSR_SCRATCH:
                begin
                    scratch <= req_data;
                end
                CSR_SREG_ADDR:
                begin
                    // Only the low four bits select a bank entry
                    sreg_addr <= req_data[3:0];
                end
                CSR_SREG_WDATA:
                begin
                    // Keep a copy so the host can read back what was staged
                    sreg_wdata_reg <= req_data;
                end
                // Header, ID, reserved and trigger indices are read only
                default: ;
            endcase
        end
    end

endmodule

/* hdl/csr_rd.sv */
// ##########################################################
// MMIO read responder
// Answers local CSR reads in the request cycle and forwards
// system-register bank data once the response port is idle
// ##########################################################

module csr_rd
    import csr_pkg::*;
#(
    parameter logic [127:0] AFU_ID = '0
)
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req_valid,
    input  logic       req_write,
    input  mmio_addr_t req_addr,
    input  tid_t       req_tid,
    input  csr_data_t  scratch,
    input  sreg_addr_t sreg_addr,
    input  csr_data_t  sreg_wdata_reg,
    input  logic       sreg_rsp_valid,
    input  csr_data_t  sreg_rsp_data,
    output logic       rd_valid,
    output tid_t       rd_tid,
    output csr_data_t  rd_data,
    output logic       sreg_req
);

    // A request hits the local CSRs when the address is even and below 16
    logic     is_rd;
    csr_idx_t idx;

    // Tag of the trigger read and the state of the system-register path
    tid_t      sreg_tid;
    logic      outstanding;
    logic      pending_valid;
    csr_data_t pending_data;

    // High when the held bank word leaves this cycle
    logic send_pending;

    assign is_rd = req_valid && !req_write && (req_addr < 16'd16) && !req_addr[0];
    assign idx   = req_addr[3:1];

    // Reading the trigger index kicks off a bank read
    assign sreg_req = is_rd && (idx == CSR_SREG_READ);

    // Response mux
    // Direct reads always win and the held bank word waits for an idle cycle
    always_comb
    begin
        rd_valid     = 1'b0;
        rd_tid       = req_tid;
        rd_data      = '0;
        send_pending = 1'b0;
        if (is_rd)
        begin
            rd_valid = 1'b1;
            case (idx)
                CSR_DFH:        rd_data = dfh_afu();
                CSR_ID_L:       rd_data = AFU_ID[63:0];
                CSR_ID_H:       rd_data = AFU_ID[127:64];
                CSR_SCRATCH:    rd_data = scratch;
                CSR_SREG_ADDR:  rd_data = csr_data_t'(sreg_addr);
                CSR_SREG_WDATA: rd_data = sreg_wdata_reg;
                // Reserved word and the trigger itself both read as zero
                default:        rd_data = '0;
            endcase
        end
        else if (pending_valid)
        begin
            rd_valid     = 1'b1;
            rd_tid       = sreg_tid;
            rd_data      = pending_data;
            send_pending = 1'b1;
        end
    end

    // Remember which request asked for the bank word
    always_ff @(posedge clk)
    begin
        if (sreg_req)
        begin
            sreg_tid <= req_tid;
        end
    end

    // Outstanding covers the whole trip, from the trigger until the word is sent
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            outstanding   <= 1'b0;
            pending_valid <= 1'b0;
        end
        else
        begin
            if (sreg_req)
                outstanding <= 1'b1;
            else if (send_pending)
                outstanding <= 1'b0;

            // Only one read is in flight, so arrival and departure never overlap
            if (sreg_rsp_valid)
                pending_valid <= 1'b1;
            else if (send_pending)
                pending_valid <= 1'b0;
        end
    end

    // Pending slot captures the bank word in the cycle it arrives
    always_ff @(posedge clk)
    begin
        if (sreg_rsp_valid)
        begin
            pending_data <= sreg_rsp_data;
        end
    end

    // The host may not trigger again before the previous word has been returned
    a_single_trigger: assert property (@(posedge clk) disable iff (reset)
        sreg_req |-> !outstanding)
        else $error("trigger read while a system-register read is outstanding");

    // The bank only answers a read that this block started and has not yet received
    a_rsp_expected: assert property (@(posedge clk) disable iff (reset)
        sreg_rsp_valid |-> (outstanding && !pending_valid))
        else $error("system-register response without an outstanding read");

endmodule

/* hdl/sreg_bank.sv */
// ##########################################################
// System-register bank
// Sixteen 64-bit registers with an immediate write port and
// a read port that answers after a fixed number of cycles
// ##########################################################

module sreg_bank
    import csr_pkg::*;
#(
    parameter int SREG_LATENCY = 3
)
(
    input  logic       clk,
    input  logic       reset,
    input  logic       sreg_req,
    input  sreg_addr_t sreg_addr,
    input  logic       sreg_wr_en,
    input  csr_data_t  wr_data,
    output logic       sreg_rsp_valid,
    output csr_data_t  sreg_rsp_data
);

    // The counter holds at most SREG_LATENCY-1, at least one bit wide
    localparam int CNT_W = (SREG_LATENCY > 1) ? $clog2(SREG_LATENCY) : 1;

    csr_data_t        regs [16];
    logic             busy;
    logic [CNT_W-1:0] cnt;
    sreg_addr_t       rd_idx;

    // Writes land at the next edge
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 16; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (sreg_wr_en)
        begin
            regs[sreg_addr] <= wr_data;
        end
    end

    // Read sequencer
    // A request loads the counter and the response fires when it reaches zero
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            cnt  <= '0;
        end
        else if (sreg_req)
        begin
            busy <= 1'b1;
            cnt  <= CNT_W'(SREG_LATENCY - 1);
        end
        else if (busy)
        begin
            if (cnt == '0)
                busy <= 1'b0;
            else
                cnt <= cnt - 1'b1;
        end
    end

    // The index is captured with the request, so later address writes do not move it
    always_ff @(posedge clk)
    begin
        if (sreg_req)
        begin
            rd_idx <= sreg_addr;
        end
    end

    // Word is read at expiry, so a write during the wait is returned
    assign sreg_rsp_valid = busy && (cnt == '0);
    assign sreg_rsp_data  = regs[rd_idx];

    // The bank serves one read at a time
    a_no_req_busy: assert property (@(posedge clk) disable iff (reset)
        sreg_req |-> !busy)
        else $error("system-register request while the bank is busy");

endmodule

/* hdl/csr_top.sv */
// ##########################################################
// MMIO control/status block top level
// Joins the write decoder, read responder and register bank
// ##########################################################

module csr_top
    import csr_pkg::*;
#(
    parameter logic [127:0] AFU_ID       = '0,
    parameter int           SREG_LATENCY = 3
)
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req_valid,
    input  logic       req_write,
    input  mmio_addr_t req_addr,
    input  tid_t       req_tid,
    input  csr_data_t  req_data,
    output logic       rd_valid,
    output tid_t       rd_tid,
    output csr_data_t  rd_data
);

    // Staged register values from the write side
    csr_data_t  scratch;
    sreg_addr_t sreg_addr;
    csr_data_t  sreg_wdata_reg;
    logic       sreg_wr_en;

    // Bank read handshake
    logic       sreg_req;
    logic       sreg_rsp_valid;
    csr_data_t  sreg_rsp_data;

    csr_wr u_wr (
        .clk(clk), .reset(reset), .req_valid(req_valid), .req_write(req_write),
        .req_addr(req_addr), .req_data(req_data), .scratch(scratch),
        .sreg_addr(sreg_addr), .sreg_wdata_reg(sreg_wdata_reg), .sreg_wr_en(sreg_wr_en)
    );

    csr_rd #(.AFU_ID(AFU_ID)) u_rd (
        .clk(clk), .reset(reset), .req_valid(req_valid), .req_write(req_write),
        .req_addr(req_addr), .req_tid(req_tid), .scratch(scratch),
        .sreg_addr(sreg_addr), .sreg_wdata_reg(sreg_wdata_reg),
        .sreg_rsp_valid(sreg_rsp_valid), .sreg_rsp_data(sreg_rsp_data),
        .rd_valid(rd_valid), .rd_tid(rd_tid), .rd_data(rd_data), .sreg_req(sreg_req)
    );

    sreg_bank #(.SREG_LATENCY(SREG_LATENCY)) u_bank (
        .clk(clk), .reset(reset), .sreg_req(sreg_req), .sreg_addr(sreg_addr),
        .sreg_wr_en(sreg_wr_en), .wr_data(req_data),
        .sreg_rsp_valid(sreg_rsp_valid), .sreg_rsp_data(sreg_rsp_data)
    );

endmodule

/* sim/csr_checker.sv */
// ##########################################################
// Response checker
// Watches the MMIO response port and compares every answer
// with the expected tid and data, then counts the results
// ##########################################################

module csr_checker
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      rd_valid,
    input  tid_t      rd_tid,
    input  csr_data_t rd_data,
    input  logic      row_valid,
    input  logic      row_rsp,
    input  logic      row_arm,
    input  int        row_num,
    input  tid_t      exp_tid,
    input  csr_data_t exp_data,
    input  csr_data_t exp_sreg,
    output int        pass_cnt,
    output int        fail_cnt,
    output int        sreg_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    int n_pass = 0;
    int n_fail = 0;
    int n_sreg = 0;

    // Expected system-register response, armed by a trigger row
    logic      armed = 1'b0;
    tid_t      sreg_tid;
    csr_data_t sreg_data;
    int        arm_row;

    assign pass_cnt = n_pass;
    assign fail_cnt = n_fail;
    assign sreg_cnt = n_sreg;

    // Sample mid-cycle, where inputs and combinational responses are settled
    always @(negedge clk)
    begin
        // A direct read owns the port in its own cycle
        if (row_valid && row_rsp)
        begin
            if (rd_valid && rd_tid == exp_tid && rd_data == exp_data)
            begin
                n_pass++;
                $display("pass: row %0d read, tid %h data %h", row_num, rd_tid, rd_data);
            end
            else
            begin
                n_fail++;
                $display("FAIL at %0t: row %0d expected tid %h data %h, got valid %b tid %h data %h",
                         $time, row_num, exp_tid, exp_data, rd_valid, rd_tid, rd_data);
            end
        end
        else if (rd_valid)
        begin
            // Any other response must be the held bank word, matched by its tag
            if (armed && rd_tid == sreg_tid)
            begin
                if (rd_data == sreg_data)
                begin
                    n_pass++;
                    $display("pass: row %0d bank word, tid %h data %h", arm_row, rd_tid, rd_data);
                end
                else
                begin
                    n_fail++;
                    $display("FAIL at %0t: row %0d bank word expected %h, got %h",
                             $time, arm_row, sreg_data, rd_data);
                end
                armed = 1'b0;
                n_sreg++;
            end
            else
            begin
                n_fail++;
                $display("FAIL at %0t: unexpected response tid %h data %h",
                         $time, rd_tid, rd_data);
            end
        end
        else if (row_valid)
        begin
            n_pass++;
            $display("pass: row %0d gave no response", row_num);
        end

        // Arm after the compare so the trigger's own zero answer is checked first
        if (row_arm)
        begin
            armed     = 1'b1;
            sreg_tid  = exp_tid;
            sreg_data = exp_sreg;
            arm_row   = row_num;
        end
    end

endmodule

/* sim/tb_csr.sv */
// ##########################################################
// Testbench for the MMIO control/status block
// Builds a table of requests with expected answers and
// drives it into the DUT one row per cycle
// ##########################################################

module tb_csr
    import csr_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [127:0] AFU_ID = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;

    // Row operations; a trigger is a read of index 7 that also arms the checker
    localparam logic [1:0] OP_RD   = 2'd0;
    localparam logic [1:0] OP_WR   = 2'd1;
    localparam logic [1:0] OP_TRIG = 2'd2;
    localparam logic [1:0] OP_WAIT = 2'd3;

    // For a trigger, data holds the bank word the response should carry
    typedef struct packed {
        logic [1:0] op;
        mmio_addr_t addr;
        tid_t       tid;
        csr_data_t  data;
        csr_data_t  exp_data;
        logic       exp_rsp;
    } row_t;

    logic       clk;
    logic       reset;
    logic       req_valid;
    logic       req_write;
    mmio_addr_t req_addr;
    tid_t       req_tid;
    csr_data_t  req_data;
    logic       rd_valid;
    tid_t       rd_tid;
    csr_data_t  rd_data;

    // Expectations handed to the checker with each row
    logic      row_valid;
    logic      row_rsp;
    logic      row_arm;
    int        row_num;
    tid_t      exp_tid;
    csr_data_t exp_data;
    csr_data_t exp_sreg;
    int        pass_cnt;
    int        fail_cnt;
    int        sreg_cnt;

    int        seed = 32'h3765_a6fc;
    int        sreg_expected = 0;
    logic      timed_out = 1'b0;
    row_t      rows [$];
    csr_data_t ro_exp [4];
    csr_data_t d_scr;

    csr_top #(.AFU_ID(AFU_ID), .SREG_LATENCY(3)) uut (
        .clk(clk), .reset(reset), .req_valid(req_valid), .req_write(req_write),
        .req_addr(req_addr), .req_tid(req_tid), .req_data(req_data),
        .rd_valid(rd_valid), .rd_tid(rd_tid), .rd_data(rd_data)
    );

    csr_checker chk (
        .clk(clk), .rd_valid(rd_valid), .rd_tid(rd_tid), .rd_data(rd_data),
        .row_valid(row_valid), .row_rsp(row_rsp), .row_arm(row_arm), .row_num(row_num),
        .exp_tid(exp_tid), .exp_data(exp_data), .exp_sreg(exp_sreg),
        .pass_cnt(pass_cnt), .fail_cnt(fail_cnt), .sreg_cnt(sreg_cnt)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic csr_data_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // Each row gets a fresh random tag
    task automatic add_row(input logic [1:0] op, input mmio_addr_t addr, input csr_data_t data,
                           input csr_data_t exp_data_in, input logic exp_rsp);
        row_t r;
        r.op       = op;
        r.addr     = addr;
        r.tid      = tid_t'($random(seed));
        r.data     = data;
        r.exp_data = exp_data_in;
        r.exp_rsp  = exp_rsp;
        rows.push_back(r);
    endtask

    task automatic build_table();
        csr_data_t d;
        // Header, ID halves and reserved word straight out of reset, then scratch
        for (int k = 0; k < 4; k++)
            add_row(OP_RD, mmio_addr_t'(2 * k), '0, ro_exp[k], 1'b1);
        add_row(OP_RD, 16'd8, '0, '0, 1'b1);
        // Scratch write is visible in the next cycle
        d_scr = rand64();
        add_row(OP_WR, 16'd8, d_scr, '0, 1'b0);
        add_row(OP_RD, 16'd8, '0, d_scr, 1'b1);
        // Read-only words ignore writes
        for (int k = 0; k < 4; k++)
            add_row(OP_WR, mmio_addr_t'(2 * k), rand64(), '0, 1'b0);
        for (int k = 0; k < 4; k++)
            add_row(OP_RD, mmio_addr_t'(2 * k), '0, ro_exp[k], 1'b1);
        // Stage entry 5, write it, read back the staging registers, then fetch it
        d = rand64();
        add_row(OP_WR, 16'd10, 64'd5, '0, 1'b0);
        add_row(OP_WR, 16'd12, d, '0, 1'b0);
        add_row(OP_RD, 16'd10, '0, 64'd5, 1'b1);
        add_row(OP_RD, 16'd12, '0, d, 1'b1);
        add_row(OP_TRIG, 16'd14, d, '0, 1'b1);
        add_row(OP_WAIT, 16'd0, '0, '0, 1'b0);
        // Entry 9, with direct reads covering the cycle the bank answers and the one after
        d = rand64();
        add_row(OP_WR, 16'd10, 64'd9, '0, 1'b0);
        add_row(OP_WR, 16'd12, d, '0, 1'b0);
        add_row(OP_TRIG, 16'd14, d, '0, 1'b1);
        add_row(OP_RD, 16'd0, '0, ro_exp[0], 1'b1);
        add_row(OP_RD, 16'd8, '0, d_scr, 1'b1);
        add_row(OP_RD, 16'd2, '0, ro_exp[1], 1'b1);
        add_row(OP_RD, 16'd4, '0, ro_exp[2], 1'b1);
        add_row(OP_WAIT, 16'd0, '0, '0, 1'b0);
        // Addresses outside the local window are ignored
        add_row(OP_RD, 16'd1, '0, '0, 1'b0);
        add_row(OP_RD, 16'd16, '0, '0, 1'b0);
        add_row(OP_RD, 16'hfff0, '0, '0, 1'b0);
        add_row(OP_WR, 16'd9, rand64(), '0, 1'b0);
        add_row(OP_WR, 16'd24, rand64(), '0, 1'b0);
        add_row(OP_RD, 16'd8, '0, d_scr, 1'b1);
    endtask

    task automatic drive_row(input row_t r);
        req_valid = (r.op != OP_WAIT);
        req_write = (r.op == OP_WR);
        req_addr  = r.addr;
        req_tid   = r.tid;
        req_data  = r.data;
        row_valid = (r.op != OP_WAIT);
        row_rsp   = r.exp_rsp;
        row_arm   = (r.op == OP_TRIG);
        exp_tid   = r.tid;
        exp_data  = r.exp_data;
        exp_sreg  = r.data;
    endtask

    // Bus stays idle while the held bank word drains to the port
    task automatic wait_sreg_rsp();
        int n;
        n = 0;
        while (sreg_cnt != sreg_expected && n < 50)
        begin
            @(posedge clk);
            n++;
        end
        if (sreg_cnt != sreg_expected)
        begin
            $display("Timeout: no system-register response arrived within 50 cycles");
            timed_out = 1'b1;
        end
    endtask

    initial
    begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_tid   = '0;
        req_data  = '0;
        row_valid = 1'b0;
        row_rsp   = 1'b0;
        row_arm   = 1'b0;
        row_num   = 0;
        exp_tid   = '0;
        exp_data  = '0;
        exp_sreg  = '0;
        // Header has feature type 1 in the top nibble and the end-of-list bit 40
        ro_exp[0] = 64'h1000_0100_0000_0000;
        ro_exp[1] = AFU_ID[63:0];
        ro_exp[2] = AFU_ID[127:64];
        ro_exp[3] = '0;
        build_table();

        repeat (4) @(posedge clk);
        #1 reset = 1'b0;

        for (int i = 0; i < rows.size(); i++)
        begin
            @(posedge clk);
            #1;
            row_num = i;
            drive_row(rows[i]);
            if (rows[i].op == OP_TRIG)
                sreg_expected++;
            if (rows[i].op == OP_WAIT)
                wait_sreg_rsp();
        end

        // Let the last row reach the checker with the bus idle afterwards
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        row_valid = 1'b0;
        row_arm   = 1'b0;
        repeat (2) @(posedge clk);

        $display("Results: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && !timed_out)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* list.f */
hdl/csr_pkg.sv
hdl/csr_wr.sv
hdl/csr_rd.sv
hdl/sreg_bank.sv
hdl/csr_top.sv
sim/csr_checker.sv
sim/tb_csr.sv

/* run.sh */
#!/bin/sh
# Build and run the CSR block testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_csr -f list.f -o tb_csr > build.log 2>&1; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_csr > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -q "^TEST PASSED$" sim.log; then
    exit 0
fi
exit 1
